// ==== lotrRc.f ====
hw/ringPkg.sv
hw/rcPkg.sv
hw/ageOrder.sv
hw/c2fBuffer.sv
hw/ringPort.sv
hw/rcTop.sv
test/tbClock.sv
test/rcTop_sva.sv
test/rcTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f lotrRc.f --top-module rcTb -Mdir "$buildDir" -o rcSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/rcSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST OK" "$logFile"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== test/rcTb.sv ====
// Own core id 5A, 4 entries; core reads use even unique addresses, injected ring data has bit 31 set
`timescale 1ns/10ps

module rcTb
    import ringPkg::*;
();

    localparam int EntriesNum = 4;
    localparam int NumTrans   = 3000;  // Stimulus cycles
    localparam int ClkPeriod  = 4;     // ns
    localparam logic [CoreIdWidth-1:0] OwnCoreId = 8'h5A;

    logic                     qClk;
    logic                     rstN;
    logic                     ringInValid;
    ringOpcodeT               ringInOpcode;
    logic [AddrWidth-1:0]     ringInAddress;
    logic [DataWidth-1:0]     ringInData;
    logic                     ringOutValid;
    ringOpcodeT               ringOutOpcode;
    logic [AddrWidth-1:0]     ringOutAddress;
    logic [DataWidth-1:0]     ringOutData;
    logic                     coreReqValid;
    ringOpcodeT               coreReqOpcode;
    logic [ThreadIdWidth-1:0] coreReqThreadId;
    logic [AddrWidth-1:0]     coreReqAddress;
    logic [DataWidth-1:0]     coreReqData;
    logic                     coreRspValid;
    logic [ThreadIdWidth-1:0] coreRspThreadId;
    logic [DataWidth-1:0]     coreRspData;
    logic                     coreStall;

    // ==========================================================
    // Reference model state
    // ==========================================================
    logic [31:0] rngState;
    logic [66:0] passQ [$];    // {forwarded, opcode, address, data}, two cycles deep
    logic [65:0] reqQ [$];     // Accepted core requests, oldest first
    logic [34:0] readQ [$];    // Outstanding reads {answered, threadId, address}
    logic [31:0] remoteQ [$];  // Reads seen on the ring, awaiting the remote node
    int          occupied;     // Entries the model thinks are taken
    bit          expStall;     // Stall the model expects in this cycle
    int          seq;          // Makes every core address unique

    tbClock clk0 (.qClk(qClk), .rstN(rstN));

    rcTop #(.EntriesNum(EntriesNum)) dut0 (.coreId(OwnCoreId), .*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: time %0t %s expected %h got %h", $time, name, exp, got);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic requireTrue(input bit cond, input string what);
        assert (cond) else begin
            $display("%s at time %0t", what, $time);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // ==========================================================
    // Per-cycle compare, sampled 1 ns after the edge
    // ==========================================================
    task automatic observeOutputs();
        logic [66:0] exp;
        logic [65:0] req;
        int          idx;
        exp = passQ.pop_front();
        if (exp[66]) begin  // Forwarded ring item owns this slot
            compareValue("ringOutValid", 32'(ringOutValid), 32'd1);
            compareValue("ringOutOpcode", 32'(ringOutOpcode), 32'(exp[65:64]));
            compareValue("ringOutAddress", ringOutAddress, exp[63:32]);
            compareValue("ringOutData", ringOutData, exp[31:0]);
        end else if (ringOutValid) begin
            // Free slot, so only the oldest core request may show
            requireTrue(!ringOutData[31] && reqQ.size() > 0,
                        "ring output carries an item that was never sent or was consumed");
            req = reqQ.pop_front();
            compareValue("ringOutOpcode", 32'(ringOutOpcode), 32'(req[65:64]));
            compareValue("ringOutAddress", ringOutAddress, req[63:32]);
            compareValue("ringOutData", ringOutData, req[31:0]);
            if (req[65:64] == WR) occupied--;     // Write entry frees on send
            else remoteQ.push_back(req[63:32]);  // Remote node answers later
        end
        expStall = (occupied == EntriesNum);
        compareValue("coreStall", 32'(coreStall), 32'(expStall));
        if (coreRspValid) begin
            idx = -1;
            foreach (readQ[i]) begin
                if (readQ[i][34] && readQ[i][31:0] == ~coreRspData) idx = i;
            end
            requireTrue(idx >= 0, "core response matches no answered read");
            compareValue("coreRspThreadId", 32'(coreRspThreadId), 32'(readQ[idx][33:32]));
            readQ.delete(idx);
            occupied--;  // Frees at the next edge
        end
    endtask

    task automatic applyStimulus(input bit newTraffic);
        logic [31:0] r;
        logic [31:0] addr;
        logic [7:0]  topByte;
        bit          forwarded;
        r = nextRand();
        forwarded = 1'b0;
        ringInValid = 1'b0;
        ringInOpcode = RD;
        ringInAddress = '0;
        ringInData = '0;
        if (remoteQ.size() > 0 && r[1:0] != 2'b00) begin
            addr = remoteQ.pop_front();
            ringInValid = 1'b1;
            ringInOpcode = RD_RSP;
            ringInAddress = addr;
            ringInData = ~addr;  // Top address bit clear, so data bit 31 set
            foreach (readQ[i]) begin
                if (readQ[i][31:0] == addr) readQ[i][34] = 1'b1;
            end
        end else if (newTraffic && r[2]) begin
            forwarded = 1'b1;
            ringInValid = 1'b1;
            ringInOpcode = ringOpcodeT'(r[4:3]);
            ringInAddress = nextRand() | 32'h1;  // Odd, never a core read
            if (r[7:5] == 3'd0) ringInAddress[31:24] = OwnCoreId;
            ringInData = nextRand() | 32'h8000_0000;
        end
        passQ.push_back({forwarded, ringInOpcode, ringInAddress, ringInData});

        // Core side, includes dropped opcodes and own core id
        r = nextRand();
        topByte = (r[5:3] == 3'd0) ? OwnCoreId : {1'b0, r[14:8]};
        coreReqValid = newTraffic && r[0];
        coreReqOpcode = ringOpcodeT'(r[2:1]);
        coreReqThreadId = r[16:15];
        coreReqAddress = {topByte, seq[21:0], 2'b00};
        coreReqData = nextRand() & 32'h7FFF_FFFF;
        seq++;
        if (coreReqValid && !expStall && topByte != OwnCoreId &&
            (coreReqOpcode == RD || coreReqOpcode == WR)) begin
            reqQ.push_back({coreReqOpcode, coreReqAddress, coreReqData});
            if (coreReqOpcode == RD) readQ.push_back({1'b0, coreReqThreadId, coreReqAddress});
            occupied++;
        end
    endtask

    task automatic runCycle(input bit newTraffic);
        @(posedge qClk);
        #1;
        observeOutputs();
        applyStimulus(newTraffic);
    endtask

    // ==========================================================
    // Main sequence and watchdog
    // ==========================================================
    initial begin
        rngState = 32'd86920;
        occupied = 0;
        expStall = 1'b0;
        seq = 0;
        applyStimulus(1'b0);  // All inputs idle
        passQ.push_back('0);  // Second stage of the ring latency
        @(posedge rstN);
        compareValue("ringOutValid", 32'(ringOutValid), 32'd0);
        compareValue("coreRspValid", 32'(coreRspValid), 32'd0);
        compareValue("coreStall", 32'(coreStall), 32'd0);
        repeat (NumTrans) runCycle(1'b1);
        while (reqQ.size() > 0 || readQ.size() > 0) runCycle(1'b0);  // Drain
        repeat (4) runCycle(1'b0);
        if (dut0.sva0.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "bound assertions failed");
        end
    end

    initial begin
        #(NumTrans * 40 * ClkPeriod);
        $display("timeout, the run did not finish within %0d cycles", NumTrans * 40);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : rcTb

// ==== test/rcTop_sva.sv ====
// Bound into rcTop; occupancy rebuilt from accepted requests, granted writes and core responses
`timescale 1ns/10ps

module rcTopSva
    import ringPkg::*;
#(
    parameter int EntriesNum = 4
) (
    input logic                   qClk,
    input logic                   rstN,
    input logic [CoreIdWidth-1:0] coreId,
    input logic                   coreReqValid,
    input ringOpcodeT             coreReqOpcode,
    input logic [AddrWidth-1:0]   coreReqAddress,
    input logic                   c2fGrant,
    input ringOpcodeT             c2fReqOpcode,
    input logic                   ringOutValid,
    input logic                   coreRspValid,
    input logic                   coreStall
);

    logic resetSeen = 1'b0;  // Previous edge was inside reset
    logic reqTaken;          // Request enters the buffer at this edge
    logic writeSent;         // Write entry frees at this edge
    int   occupiedQ;         // Entries taken, counted from port events
    int   failCount = 0;     // Failed assertions so far

    // Only RD and WR to another core while not stalled
    assign reqTaken  = coreReqValid && !coreStall &&
                       ((coreReqOpcode == RD) || (coreReqOpcode == WR)) &&
                       (coreReqAddress[CoreIdMsb -: CoreIdWidth] != coreId);
    assign writeSent = c2fGrant && (c2fReqOpcode == WR);

    always @(posedge qClk) begin
        resetSeen <= !rstN;
    end

    always @(posedge qClk) begin
        if (!rstN) occupiedQ <= 0;
        else       occupiedQ <= occupiedQ + int'(reqTaken) - int'(writeSent) - int'(coreRspValid);
    end

    // Buffer already cleared by one reset edge
    rspQuietInReset: assert property (@(posedge qClk) (!rstN && resetSeen) |-> !coreRspValid)
        else begin
            failCount++;
            $error("coreRspValid high during reset");
        end

    ringIdleAfterReset: assert property (@(posedge qClk) $rose(rstN) |-> !ringOutValid)
        else begin
            failCount++;
            $error("ringOutValid high in the first cycle after reset");
        end

    // Room left means no stall
    noFalseStall: assert property (@(posedge qClk) disable iff (!rstN)
                                   (occupiedQ < EntriesNum) |-> !coreStall)
        else begin
            failCount++;
            $error("coreStall high with fewer than EntriesNum entries occupied");
        end

endmodule : rcTopSva

bind rcTop rcTopSva #(
    .EntriesNum (EntriesNum)
) sva0 (
    .qClk           (qClk),
    .rstN           (rstN),
    .coreId         (coreId),
    .coreReqValid   (coreReqValid),
    .coreReqOpcode  (coreReqOpcode),
    .coreReqAddress (coreReqAddress),
    .c2fGrant       (c2fGrant),
    .c2fReqOpcode   (c2fReqOpcode),
    .ringOutValid   (ringOutValid),
    .coreRspValid   (coreRspValid),
    .coreStall      (coreStall)
);

// ==== test/tbClock.sv ====
// Free-running 4 ns clock; rstN held low over the first 8 rising edges, released 1 ns after one
`timescale 1ns/10ps

module tbClock #(
    parameter int HalfPeriod  = 2,  // ns
    parameter int ResetCycles = 8
) (
    output logic qClk,
    output logic rstN
);

    initial begin
        qClk = 1'b0;
        forever #(HalfPeriod) qClk = ~qClk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge qClk);
        #1;
        rstN = 1'b1;  // Off the edge like every other input
    end

endmodule : tbClock

// ==== hw/rcTop.sv ====
// Ring controller top: no F2C path, broadcast writes and own-core requests are dropped
`timescale 1ns/10ps

module rcTop
    import ringPkg::*;
#(
    parameter int EntriesNum = 4  // Power of two, 2 to 16
) (
    input  logic                     qClk,
    input  logic                     rstN,
    input  logic [CoreIdWidth-1:0]   coreId,
    // Ring in
    input  logic                     ringInValid,
    input  ringOpcodeT               ringInOpcode,
    input  logic [AddrWidth-1:0]     ringInAddress,
    input  logic [DataWidth-1:0]     ringInData,
    // Ring out
    output logic                     ringOutValid,
    output ringOpcodeT               ringOutOpcode,
    output logic [AddrWidth-1:0]     ringOutAddress,
    output logic [DataWidth-1:0]     ringOutData,
    // Core request
    input  logic                     coreReqValid,
    input  ringOpcodeT               coreReqOpcode,
    input  logic [ThreadIdWidth-1:0] coreReqThreadId,
    input  logic [AddrWidth-1:0]     coreReqAddress,
    input  logic [DataWidth-1:0]     coreReqData,
    // Core response
    output logic                     coreRspValid,
    output logic [ThreadIdWidth-1:0] coreRspThreadId,
    output logic [DataWidth-1:0]     coreRspData,
    output logic                     coreStall
);

    // Registered ring input, shared by both blocks
    logic                 ringValidQ501;
    ringOpcodeT           ringOpcodeQ501;
    logic [AddrWidth-1:0] ringAddressQ501;
    logic [DataWidth-1:0] ringDataQ501;

    logic                 rspConsumed;
    logic                 c2fReqValid;
    ringOpcodeT           c2fReqOpcode;
    logic [AddrWidth-1:0] c2fReqAddress;
    logic [DataWidth-1:0] c2fReqData;
    logic                 c2fGrant;

    ringPort ringPort0 (.*);

    c2fBuffer #(
        .EntriesNum (EntriesNum)
    ) c2fBuffer0 (.*);

endmodule : rcTop

// ==== hw/ringPort.sv ====
// Ring port: no back-pressure, ring traffic always wins the output slot over core requests
`timescale 1ns/10ps

module ringPort
    import ringPkg::*;
    import rcPkg::*;
(
    input  logic                 qClk,
    input  logic                 rstN,
    // Ring input
    input  logic                 ringInValid,
    input  ringOpcodeT           ringInOpcode,
    input  logic [AddrWidth-1:0] ringInAddress,
    input  logic [DataWidth-1:0] ringInData,
    // Registered ring input toward the buffer
    output logic                 ringValidQ501,
    output ringOpcodeT           ringOpcodeQ501,
    output logic [AddrWidth-1:0] ringAddressQ501,
    output logic [DataWidth-1:0] ringDataQ501,
    input  logic                 rspConsumed,
    // Pending core request
    input  logic                 c2fReqValid,
    input  ringOpcodeT           c2fReqOpcode,
    input  logic [AddrWidth-1:0] c2fReqAddress,
    input  logic [DataWidth-1:0] c2fReqData,
    output logic                 c2fGrant,
    // Ring output
    output logic                 ringOutValid,
    output ringOpcodeT           ringOutOpcode,
    output logic [AddrWidth-1:0] ringOutAddress,
    output logic [DataWidth-1:0] ringOutData
);

    ringSelT              ringSel;
    logic                 outValidNext;
    ringOpcodeT           outOpcodeNext;
    logic [AddrWidth-1:0] outAddressNext;
    logic [DataWidth-1:0] outDataNext;

    // ==========================================================
    // Input stage
    // ==========================================================
    always_ff @(posedge qClk) begin
        if (!rstN) ringValidQ501 <= 1'b0;
        else       ringValidQ501 <= ringInValid;
    end

    always_ff @(posedge qClk) begin
        ringOpcodeQ501  <= ringInOpcode;
        ringAddressQ501 <= ringInAddress;
        ringDataQ501    <= ringInData;
    end

    // ==========================================================
    // Output select
    // ==========================================================
    always_comb begin
        if (ringValidQ501 && !rspConsumed) ringSel = RING_INPUT;  // Forward first
        else if (c2fReqValid)              ringSel = C2F_REQUEST; // Free slot, send request
        else                               ringSel = NOP;
    end

    assign c2fGrant = (ringSel == C2F_REQUEST);

    always_comb begin
        unique case (ringSel)
            RING_INPUT: begin
                outValidNext   = 1'b1;
                outOpcodeNext  = ringOpcodeQ501;
                outAddressNext = ringAddressQ501;
                outDataNext    = ringDataQ501;
            end
            C2F_REQUEST: begin
                outValidNext   = 1'b1;
                outOpcodeNext  = c2fReqOpcode;
                outAddressNext = c2fReqAddress;
                outDataNext    = c2fReqData;
            end
            default: begin  // Idle slot, all fields zero
                outValidNext   = 1'b0;
                outOpcodeNext  = RD;  // Zero encoding
                outAddressNext = '0;
                outDataNext    = '0;
            end
        endcase
    end

    // Output stage
    always_ff @(posedge qClk) begin
        if (!rstN) ringOutValid <= 1'b0;
        else       ringOutValid <= outValidNext;
    end

    always_ff @(posedge qClk) begin
        ringOutOpcode  <= outOpcodeNext;
        ringOutAddress <= outAddressNext;
        ringOutData    <= outDataNext;
    end

endmodule : ringPort

// ==== hw/c2fBuffer.sv ====
// Core request buffer; RD_RSP matched by full address, so outstanding read addresses must be unique
`timescale 1ns/10ps

module c2fBuffer
    import ringPkg::*;
    import rcPkg::*;
#(
    parameter int EntriesNum = 4
) (
    input  logic                     qClk,
    input  logic                     rstN,
    input  logic [CoreIdWidth-1:0]   coreId,
    // Core request
    input  logic                     coreReqValid,
    input  ringOpcodeT               coreReqOpcode,
    input  logic [ThreadIdWidth-1:0] coreReqThreadId,
    input  logic [AddrWidth-1:0]     coreReqAddress,
    input  logic [DataWidth-1:0]     coreReqData,
    // Registered ring input
    input  logic                     ringValidQ501,
    input  ringOpcodeT               ringOpcodeQ501,
    input  logic [AddrWidth-1:0]     ringAddressQ501,
    input  logic [DataWidth-1:0]     ringDataQ501,
    output logic                     rspConsumed,
    // Oldest pending request toward the ring
    output logic                     c2fReqValid,
    output ringOpcodeT               c2fReqOpcode,
    output logic [AddrWidth-1:0]     c2fReqAddress,
    output logic [DataWidth-1:0]     c2fReqData,
    input  logic                     c2fGrant,
    // Core response
    output logic                     coreRspValid,
    output logic [ThreadIdWidth-1:0] coreRspThreadId,
    output logic [DataWidth-1:0]     coreRspData,
    output logic                     coreStall
);

    localparam int IdxWidth = $clog2(EntriesNum);

    // Entry storage
    entryStateT                 stateQ    [EntriesNum];
    entryStateT                 stateNext [EntriesNum];
    ringOpcodeT                 opcodeQ   [EntriesNum];
    logic [ThreadIdWidth-1:0]   threadIdQ [EntriesNum];
    logic [AddrWidth-1:0]       addressQ  [EntriesNum];
    logic [DataWidth-1:0]       dataQ     [EntriesNum];

    logic [EntriesNum-1:0]      freeVec;
    logic [EntriesNum-1:0]      firstFree;
    logic [EntriesNum-1:0]      allocOneHot;
    logic [EntriesNum-1:0]      deallocVec;
    logic [EntriesNum-1:0]      matchVec;     // READ_PRGRS entries hit by the ring item
    logic [EntriesNum-1:0]      matchFirst;
    logic [EntriesNum-1:0]      readyMask;
    logic [EntriesNum-1:0]      sendMask;
    logic [EntriesNum-1:0]      sendTaken;    // Oldest send entry won the ring slot
    logic [EntriesNum-1:0]      rspTaken;     // Oldest ready entry shown to the core
    logic [IdxWidth-1:0]        oldestReady;
    logic [IdxWidth-1:0]        oldestSend;
    logic                       reqAccept;

    // ==========================================================
    // Entry status vectors
    // ==========================================================
    always_comb begin
        for (int i = 0; i < EntriesNum; i++) begin
            freeVec[i]   = (stateQ[i] == FREE);
            readyMask[i] = (stateQ[i] == READ_RDY);
            sendMask[i]  = (stateQ[i] == READ) || (stateQ[i] == WRITE);
            matchVec[i]  = ringValidQ501 && (ringOpcodeQ501 == RD_RSP) &&
                           (stateQ[i] == READ_PRGRS) && (ringAddressQ501 == addressQ[i]);
        end
    end

    assign coreStall   = ~|freeVec;  // No free slot left
    assign firstFree   = EntriesNum'(findFirst(MaxEntries'(freeVec)));
    assign matchFirst  = EntriesNum'(findFirst(MaxEntries'(matchVec)));
    assign rspConsumed = |matchVec;

    // Only RD and WR to another core are taken, the rest is dropped
    assign reqAccept   = coreReqValid && !coreStall &&
                         ((coreReqOpcode == RD) || (coreReqOpcode == WR)) &&
                         (coreReqAddress[CoreIdMsb -: CoreIdWidth] != coreId);
    assign allocOneHot = reqAccept ? firstFree : '0;

    assign sendTaken   = c2fGrant ? (EntriesNum'(1) << oldestSend) : '0;
    assign rspTaken    = (|readyMask) ? (EntriesNum'(1) << oldestReady) : '0;

    // ==========================================================
    // Per-entry FSM
    // ==========================================================
    always_comb begin
        for (int i = 0; i < EntriesNum; i++) begin
            stateNext[i] = stateQ[i];
            unique case (stateQ[i])
                FREE:       if (allocOneHot[i]) stateNext[i] = (coreReqOpcode == RD) ? READ : WRITE;
                WRITE:      if (sendTaken[i])   stateNext[i] = FREE;        // Done once on the ring
                READ:       if (sendTaken[i])   stateNext[i] = READ_PRGRS;
                READ_PRGRS: if (matchFirst[i])  stateNext[i] = READ_RDY;
                READ_RDY:   if (rspTaken[i])    stateNext[i] = FREE;        // Core took it
                default:    stateNext[i] = FREE;
            endcase
            deallocVec[i] = (stateQ[i] != FREE) && (stateNext[i] == FREE);
        end
    end

    always_ff @(posedge qClk) begin
        for (int i = 0; i < EntriesNum; i++) begin
            if (!rstN) stateQ[i] <= FREE;
            else       stateQ[i] <= stateNext[i];
        end
    end

    // Payload; alloc and match never hit the same entry
    always_ff @(posedge qClk) begin
        for (int i = 0; i < EntriesNum; i++) begin
            if (allocOneHot[i]) begin
                opcodeQ[i]   <= coreReqOpcode;
                threadIdQ[i] <= coreReqThreadId;
                addressQ[i]  <= coreReqAddress;
                dataQ[i]     <= coreReqData;
            end else if (matchFirst[i]) begin
                dataQ[i]     <= ringDataQ501;  // Read data from the responder
            end
        end
    end

    // ==========================================================
    // Ordering and outputs
    // ==========================================================
    ageOrder #(
        .EntriesNum (EntriesNum)
    ) ageOrder0 (
        .qClk        (qClk),
        .rstN        (rstN),
        .allocOneHot (allocOneHot),
        .deallocVec  (deallocVec),
        .readyMask   (readyMask),
        .sendMask    (sendMask),
        .oldestReady (oldestReady),
        .oldestSend  (oldestSend)
    );

    assign c2fReqValid     = |sendMask;
    assign c2fReqOpcode    = opcodeQ[oldestSend];
    assign c2fReqAddress   = addressQ[oldestSend];
    assign c2fReqData      = dataQ[oldestSend];

    assign coreRspValid    = |readyMask;  // Strobe, core always accepts
    assign coreRspThreadId = threadIdQ[oldestReady];
    assign coreRspData     = dataQ[oldestReady];

endmodule : c2fBuffer

// ==== hw/ageOrder.sv ====
// Age matrix for 2 to 16 entries; outputs are don't-care while their mask is all zero
`timescale 1ns/10ps

module ageOrder #(
    parameter int EntriesNum = 4
) (
    input  logic                          qClk,
    input  logic                          rstN,
    input  logic [EntriesNum-1:0]         allocOneHot,  // Entry taking a new request
    input  logic [EntriesNum-1:0]         deallocVec,   // Entries going back to FREE
    input  logic [EntriesNum-1:0]         readyMask,    // READ_RDY entries
    input  logic [EntriesNum-1:0]         sendMask,     // READ and WRITE entries
    output logic [$clog2(EntriesNum)-1:0] oldestReady,
    output logic [$clog2(EntriesNum)-1:0] oldestSend
);

    localparam int IdxWidth = $clog2(EntriesNum);

    // olderQ[r][c] set means entry c was allocated before entry r
    logic [EntriesNum-1:0][EntriesNum-1:0] olderQ;

    // ==========================================================
    // Matrix update
    // ==========================================================
    always_ff @(posedge qClk) begin
        if (!rstN) begin
            olderQ <= '0;
        end else begin
            for (int r = 0; r < EntriesNum; r++) begin
                for (int c = 0; c < EntriesNum; c++) begin
                    if (allocOneHot[r]) begin
                        // Newcomer is younger than everyone else
                        olderQ[r][c] <= (r != c);
                    end else if (allocOneHot[c] || deallocVec[r] || deallocVec[c]) begin
                        olderQ[r][c] <= 1'b0;  // Newcomer or leaver is older than nobody
                    end
                end
            end
        end
    end

    // ==========================================================
    // Oldest lookup
    // ==========================================================
    // Stale bits toward free entries are harmless, the masks drop them
    always_comb begin
        oldestReady = '0;
        oldestSend  = '0;
        for (int i = 0; i < EntriesNum; i++) begin
            if (readyMask[i] && !(|(olderQ[i] & readyMask))) begin
                oldestReady = IdxWidth'(i);
            end
            if (sendMask[i] && !(|(olderQ[i] & sendMask))) begin
                oldestSend = IdxWidth'(i);
            end
        end
    end

endmodule : ageOrder

// ==== hw/rcPkg.sv ====
// Controller internals: entry states, ring output select, find-first for up to 16 entries

package rcPkg;

    // Widest buffer that findFirst covers
    localparam int MaxEntries = 16;

    // Per-entry state of the core request buffer
    typedef enum logic [2:0] {
        FREE       = 3'b000,  // Slot can take a new request
        WRITE      = 3'b001,  // Write waiting for a ring slot
        READ       = 3'b010,  // Read waiting for a ring slot
        READ_PRGRS = 3'b011,  // Read on the ring, waiting for RD_RSP
        READ_RDY   = 3'b100   // Response data held for the core
    } entryStateT;

    // Source of the next ring output slot
    typedef enum logic [1:0] {
        NOP         = 2'b00,  // Idle slot
        RING_INPUT  = 2'b01,  // Forward registered ring item
        C2F_REQUEST = 2'b10   // Oldest pending core request
    } ringSelT;

    // One-hot of the lowest set bit, zero when vec is zero
    function automatic logic [MaxEntries-1:0] findFirst(input logic [MaxEntries-1:0] vec);
        return vec & (~vec + MaxEntries'(1));
    endfunction

endpackage : rcPkg

// ==== hw/ringPkg.sv ====
// Ring format: 32-bit address and data, core id in the top address byte, 2-bit opcode

package ringPkg;

    // ==========================================================
    // Field widths
    // ==========================================================
    localparam int AddrWidth     = 32;
    localparam int DataWidth     = 32;
    localparam int CoreIdWidth   = 8;
    localparam int CoreIdMsb     = AddrWidth - 1;  // Core id is the address top byte
    localparam int ThreadIdWidth = 2;

    // ==========================================================
    // Ring command
    // ==========================================================
    // WR_BCAST is only recognised so it can be dropped
    typedef enum logic [1:0] {
        RD       = 2'b00,  // Read request
        RD_RSP   = 2'b01,  // Read response, data holds the read value
        WR       = 2'b10,  // Write request
        WR_BCAST = 2'b11   // Broadcast write, not supported here
    } ringOpcodeT;

endpackage : ringPkg
